// File: axis_settings.svh
`ifndef AXIS_SETTINGS_SVH
`define AXIS_SETTINGS_SVH

// ======================================================================
// Stream geometry
// ======================================================================

// Bytes carried per beat
`define AXIS_DATA_BYTES 8

// Sideband routing fields
`define AXIS_ID_WIDTH   4
`define AXIS_DEST_WIDTH 4

// ======================================================================
// Buffer depths
// ======================================================================
`define AXIS_FIFO_DEPTH 16
// Beat capacity of the packet buffer, must be a power of two
`define AXIS_PKT_DEPTH  64

`endif

// File: axis_pkg.sv
`default_nettype none

`include "axis_settings.svh"

package axis_pkg;

    // ======================================================================
    // Stream beat
    // ======================================================================

    // One AXI4-Stream transfer, carried on every link of the path
    typedef struct packed {
        logic [`AXIS_DATA_BYTES*8-1:0]  tdata;
        logic [`AXIS_DATA_BYTES-1:0]    tkeep;
        logic                           tlast;
        logic [`AXIS_ID_WIDTH-1:0]      tid;
        logic [`AXIS_DEST_WIDTH-1:0]    tdest;
        // Error flag, only meaningful on the last beat of a packet
        logic                           tuser;
    } axis_beat_t;

endpackage

`default_nettype wire

// File: axis_full_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_settings.svh"

module axis_full_pipe import axis_pkg::*; (
    input  logic       axis_out_if,
    input  logic       rst_n,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    axis_beat_t skid_beat;
    logic       skid_valid;
    logic       in_xfer;
    logic       out_free;
    logic       load_out;
    logic       load_skid;

    assign in_xfer  = in_valid && in_ready;
    // Output register can take a new beat this cycle
    assign out_free = !out_valid || out_ready;

    assign load_out  = out_free && (skid_valid || in_xfer);
    // Beat accepted while the output is stalled lands in the skid register
    assign load_skid = !out_free && in_xfer;

    // ======================================================================
    // Control flops
    // ======================================================================
    always_ff @(posedge axis_out_if or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else if (out_free) begin
            // Skid content drains first, input is blocked while it is full
            out_valid  <= skid_valid || in_xfer;
            skid_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else if (in_xfer) begin
            skid_valid <= 1'b1;
            in_ready   <= 1'b0;
        end
    end

    // Payload registers
    always_ff @(posedge axis_out_if) begin
        if (load_out) begin
            out_beat <= skid_valid ? skid_beat : in_beat;
        end
        if (load_skid) begin
            skid_beat <= in_beat;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    // Stalled output holds its beat until the transfer
    assert property (@(posedge axis_out_if) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

`default_nettype wire

// File: axis_fifo_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_settings.svh"

module axis_fifo_sync import axis_pkg::*; #(
    parameter int DEPTH = `AXIS_FIFO_DEPTH
) (
    input  logic       axis_out_if,
    input  logic       rst_n,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    axis_beat_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] rd_ptr_nxt;
    logic [CW-1:0] count;
    logic          wr_en;
    logic          rd_en;
    logic          full;

    // Circular increment, DEPTH need not be a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CW'(DEPTH));
    assign in_ready  = !full;
    assign out_valid = (count != '0);

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Address of the entry shown at the output after this edge
    assign rd_ptr_nxt = rd_en ? ptr_inc(rd_ptr) : rd_ptr;

    // ======================================================================
    // Pointers and occupancy
    // ======================================================================
    always_ff @(posedge axis_out_if or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr <= rd_ptr_nxt;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ======================================================================
    // Storage and registered read
    // ======================================================================
    always_ff @(posedge axis_out_if) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // A beat written into the slot about to be read bypasses the array
    always_ff @(posedge axis_out_if) begin
        if (wr_en && (wr_ptr == rd_ptr_nxt)) begin
            out_beat <= in_beat;
        end else begin
            out_beat <= mem[rd_ptr_nxt];
        end
    end

    // Occupancy bound
    assert property (@(posedge axis_out_if) disable iff (!rst_n)
        count <= CW'(DEPTH));

    // Full and not read means nothing was written at the edge
    assert property (@(posedge axis_out_if) disable iff (!rst_n)
        full && !rd_en |=> full && $stable(wr_ptr));

endmodule

`default_nettype wire

// File: axis_pkt_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_settings.svh"

module axis_pkt_fifo import axis_pkg::*; (
    input  logic       axis_out_if,
    input  logic       rst_n,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       pkt_drop
);

    localparam int PKT_DEPTH = `AXIS_PKT_DEPTH;
    localparam int AW        = $clog2(PKT_DEPTH);
    // Pointers carry one wrap bit above the address
    localparam int PW        = AW + 1;

    axis_beat_t    mem [PKT_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] cmt_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] fill;
    logic          ovfl;
    logic          in_xfer;
    logic          out_xfer;
    logic          full;
    logic          store;
    logic          pkt_end;
    logic          pkt_bad;

    // Overflow is absorbed, never pushed back upstream
    assign in_ready = 1'b1;

    assign in_xfer  = in_valid && in_ready;
    assign out_xfer = out_valid && out_ready;

    // Speculative fill includes the packet still being received
    assign fill  = wr_ptr - rd_ptr;
    assign full  = (fill == PW'(PKT_DEPTH));
    assign store = in_xfer && !ovfl && !full;

    assign pkt_end = in_xfer && in_beat.tlast;
    // Error flag, earlier overflow, or no room for the last beat itself
    assign pkt_bad = in_beat.tuser || ovfl || full;

    // ======================================================================
    // Write side, commit and discard
    // ======================================================================
    always_ff @(posedge axis_out_if or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            cmt_ptr  <= '0;
            rd_ptr   <= '0;
            ovfl     <= 1'b0;
            pkt_drop <= 1'b0;
        end else begin
            pkt_drop <= pkt_end && pkt_bad;
            if (out_xfer) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (pkt_end) begin
                ovfl <= 1'b0;
                if (pkt_bad) begin
                    // Rewind over the whole packet
                    wr_ptr <= cmt_ptr;
                end else begin
                    wr_ptr  <= wr_ptr + 1'b1;
                    cmt_ptr <= wr_ptr + 1'b1;
                end
            end else if (in_xfer) begin
                if (store) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end else begin
                    // Rest of this packet is swallowed up to its last beat
                    ovfl <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge axis_out_if) begin
        if (store) begin
            mem[wr_ptr[AW-1:0]] <= in_beat;
        end
    end

    // ======================================================================
    // Read side
    // ======================================================================

    // Only committed beats are visible, so a released packet runs without gaps
    assign out_valid = (rd_ptr != cmt_ptr);
    assign out_beat  = mem[rd_ptr[AW-1:0]];

    // Reads stay behind the commit point
    assert property (@(posedge axis_out_if) disable iff (!rst_n)
        (cmt_ptr - rd_ptr) <= PW'(PKT_DEPTH));

    // No valid gap inside a packet once it has started
    assert property (@(posedge axis_out_if) disable iff (!rst_n)
        out_valid && out_ready && !out_beat.tlast |=> out_valid);

endmodule

`default_nettype wire

// File: axis_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_settings.svh"

module axis_stream_top import axis_pkg::*; (
    input  logic       axis_out_if,
    input  logic       rst_n,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       pkt_drop
);

    // Register stage to beat FIFO
    axis_beat_t pipe_beat;
    logic       pipe_valid;
    logic       pipe_ready;

    // Beat FIFO to packet FIFO
    axis_beat_t fifo_beat;
    logic       fifo_valid;
    logic       fifo_ready;

    axis_full_pipe axis_full_pipe_inst (
        .axis_out_if (axis_out_if),
        .rst_n       (rst_n),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_beat    (pipe_beat),
        .out_valid   (pipe_valid),
        .out_ready   (pipe_ready)
    );

    axis_fifo_sync #(
        .DEPTH (`AXIS_FIFO_DEPTH)
    ) axis_fifo_sync_inst (
        .axis_out_if (axis_out_if),
        .rst_n       (rst_n),
        .in_beat     (pipe_beat),
        .in_valid    (pipe_valid),
        .in_ready    (pipe_ready),
        .out_beat    (fifo_beat),
        .out_valid   (fifo_valid),
        .out_ready   (fifo_ready)
    );

    axis_pkt_fifo axis_pkt_fifo_inst (
        .axis_out_if (axis_out_if),
        .rst_n       (rst_n),
        .in_beat     (fifo_beat),
        .in_valid    (fifo_valid),
        .in_ready    (fifo_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .pkt_drop    (pkt_drop)
    );

endmodule

`default_nettype wire

// File: tb_axis_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_settings.svh"

module tb_axis_checker import axis_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    input  logic       in_ready,
    input  axis_beat_t out_beat,
    input  logic       out_valid,
    input  logic       out_ready,
    input  logic       pkt_drop,
    output int         err_count,
    output int         pending,
    output int         exp_drops,
    output int         seen_drops
);

    localparam int PKT_DEPTH = `AXIS_PKT_DEPTH;

    // Beats of the packet still arriving, and beats expected at the output
    axis_beat_t cur_pkt [$];
    axis_beat_t exp_q [$];
    // Inside a released packet at the output
    logic       in_pkt;
    // Reset was active on the previous edge
    logic       was_reset;

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want);
            err_count++;
        end
    endtask

    task automatic report(input string what);
        $display("ERROR at %0t: %s", $time, what);
        err_count++;
    endtask

    // ======================================================================
    // Prediction and comparison
    // ======================================================================
    always @(posedge clk) begin
        axis_beat_t want;
        if (!rst_n) begin
            cur_pkt.delete();
            exp_q.delete();
            in_pkt     = 1'b0;
            was_reset  = 1'b1;
            exp_drops  = 0;
            seen_drops = 0;
        end else begin
            // Idle state on the first edge after reset
            if (was_reset) begin
                check_field("in_ready", 64'(in_ready), 64'd1);
                check_field("out_valid", 64'(out_valid), 64'd0);
                check_field("pkt_drop", 64'(pkt_drop), 64'd0);
                was_reset = 1'b0;
            end
            if (in_valid && in_ready) begin
                cur_pkt.push_back(in_beat);
                if (in_beat.tlast) begin
                    // Error flag on the last beat, or too long for the buffer
                    if (in_beat.tuser || cur_pkt.size() > PKT_DEPTH) begin
                        exp_drops++;
                    end else begin
                        foreach (cur_pkt[i]) begin
                            exp_q.push_back(cur_pkt[i]);
                        end
                    end
                    cur_pkt.delete();
                end
            end
            if (in_pkt && !out_valid) begin
                report("out_valid dropped inside a released packet");
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report("output beat appeared with no packet expected");
                end else begin
                    want = exp_q.pop_front();
                    check_field("out_beat.tdata", 64'(out_beat.tdata), 64'(want.tdata));
                    check_field("out_beat.tkeep", 64'(out_beat.tkeep), 64'(want.tkeep));
                    check_field("out_beat.tlast", 64'(out_beat.tlast), 64'(want.tlast));
                    check_field("out_beat.tid", 64'(out_beat.tid), 64'(want.tid));
                    check_field("out_beat.tdest", 64'(out_beat.tdest), 64'(want.tdest));
                    check_field("out_beat.tuser", 64'(out_beat.tuser), 64'(want.tuser));
                end
                in_pkt = !out_beat.tlast;
            end
            if (pkt_drop) begin
                seen_drops++;
                if (seen_drops > exp_drops) begin
                    report("pkt_drop pulsed with no discarded packet predicted");
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// File: tb_axis_stream.sv
`timescale 1ns/1ps
`default_nettype none

`include "axis_settings.svh"

module tb_axis_stream import axis_pkg::*; ();

    localparam int DATA_W     = `AXIS_DATA_BYTES * 8;
    localparam int NUM_ROWS   = 7;
    localparam int READY_WAIT = 1000;
    localparam int DRAIN_WAIT = 5000;

    // One row per test
    typedef struct packed {
        int pkts;
        int len;
        bit err_last;
        int gap;
        bit rand_ready;
    } test_row_t;

    // ======================================================================
    // Stimulus table
    // ======================================================================
    localparam test_row_t ROWS [NUM_ROWS] = '{
        '{1, 5, 1'b0, 0, 1'b0},   // single packet
        '{20, 4, 1'b0, 0, 1'b0},  // back-to-back stream
        '{20, 3, 1'b0, 3, 1'b1},  // random out_ready and input gaps
        '{3, 6, 1'b1, 0, 1'b0},   // last packet flagged bad
        '{2, 4, 1'b0, 1, 1'b1},   // traffic after the bad packet
        '{1, 80, 1'b0, 0, 1'b0},  // longer than the packet buffer
        '{1, 8, 1'b0, 0, 1'b0}    // normal packet after the overflow
    };

    logic       clk;
    logic       rst_n;
    axis_beat_t in_beat;
    logic       in_valid;
    logic       in_ready;
    axis_beat_t out_beat;
    logic       out_valid;
    logic       out_ready;
    logic       pkt_drop;

    int         chk_errors;
    int         chk_pending;
    int         chk_exp_drops;
    int         chk_seen_drops;
    bit         rand_ready;
    bit         timed_out;

    always #50 clk = ~clk;

    // Output back-pressure
    always @(negedge clk) begin
        if (rand_ready) begin
            out_ready <= ($urandom() % 2) == 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    axis_stream_top axis_stream_top_inst (
        .axis_out_if (clk),
        .rst_n       (rst_n),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .pkt_drop    (pkt_drop)
    );

    tb_axis_checker tb_axis_checker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .pkt_drop   (pkt_drop),
        .err_count  (chk_errors),
        .pending    (chk_pending),
        .exp_drops  (chk_exp_drops),
        .seen_drops (chk_seen_drops)
    );

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_beat(input axis_beat_t beat);
        int cycles;
        cycles   = 0;
        in_beat  = beat;
        in_valid = 1'b1;
        while (!in_ready && cycles < READY_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!in_ready) begin
            $display("ERROR: in_ready stayed low for %0d cycles", READY_WAIT);
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic run_row(input test_row_t row);
        axis_beat_t beat;
        for (int p = 0; p < row.pkts && !timed_out; p++) begin
            beat.tid   = `AXIS_ID_WIDTH'($urandom());
            beat.tdest = `AXIS_DEST_WIDTH'($urandom());
            for (int b = 0; b < row.len && !timed_out; b++) begin
                beat.tdata = DATA_W'({$urandom(), $urandom()});
                beat.tkeep = `AXIS_DATA_BYTES'($urandom());
                beat.tlast = (b == row.len - 1);
                beat.tuser = beat.tlast && row.err_last && (p == row.pkts - 1);
                send_beat(beat);
                repeat ($urandom() % (row.gap + 1)) @(negedge clk);
            end
        end
    endtask

    // Output idle, every expected beat seen, every predicted drop pulsed
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (!(chk_pending == 0 && !out_valid && chk_seen_drops >= chk_exp_drops)
               && cycles < DRAIN_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= DRAIN_WAIT) begin
            $display("ERROR: output did not drain within %0d cycles", DRAIN_WAIT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int errs_before;
        int pass_tests;
        int fail_tests;
        void'($urandom(32'h88c8_8d10));
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_beat    = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        rand_ready = 1'b0;
        timed_out  = 1'b0;
        pass_tests = 0;
        fail_tests = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            errs_before = chk_errors;
            rand_ready  = ROWS[i].rand_ready;
            run_row(ROWS[i]);
            if (!timed_out) begin
                wait_drained();
            end
            rand_ready = 1'b0;
            if (!timed_out && chk_errors == errs_before) begin
                pass_tests++;
                $display("test %0d: %0d x %0d beats ok", i + 1, ROWS[i].pkts, ROWS[i].len);
            end else begin
                fail_tests++;
                $display("test %0d: %0d x %0d beats FAILED", i + 1, ROWS[i].pkts,
                         ROWS[i].len);
            end
        end

        $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && !timed_out && chk_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
axis_pkg.sv
axis_full_pipe.sv
axis_fifo_sync.sv
axis_pkt_fifo.sv
axis_stream_top.sv
tb_axis_checker.sv
tb_axis_stream.sv

// File: Makefile
TOP := tb_axis_stream

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module axis_stream_top -f filelist.f
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
